// ==== src/gat_aggr_defines.svh ====
// GAT aggregation parameters
`ifndef GAT_AGGR_DEFINES_SVH
`define GAT_AGGR_DEFINES_SVH

// ======================================================================
// Array shape
// ======================================================================
`define GAT_NUM_FEATURE_OUT 4
`define GAT_MAX_NODES 8

// ======================================================================
// Data widths
// ======================================================================
// Signed integer Wh element
`define GAT_WH_WIDTH 12
// Unsigned coefficient, 15 fractional bits
`define GAT_ALPHA_WIDTH 16
`define GAT_FEAT_WIDTH 32
// One extra bit for the sign of the running sum
`define GAT_ACC_WIDTH (`GAT_FEAT_WIDTH + 1)

// Depths
`define GAT_WH_DEPTH 64
`define GAT_FEAT_DEPTH 64
`define GAT_ALPHA_FIFO_DEPTH 16

`endif

// ==== src/gat_aggr_pkg.sv ====
// GAT aggregation types
`include "gat_aggr_defines.svh"

package gat_aggr_pkg;

  // Scalar values
  typedef logic signed [`GAT_WH_WIDTH-1:0] wh_val_t;
  typedef logic [`GAT_ALPHA_WIDTH-1:0] alpha_t;
  typedef logic [$clog2(`GAT_MAX_NODES + 1)-1:0] node_cnt_t;
  typedef logic [$clog2(`GAT_WH_DEPTH)-1:0] wh_addr_t;
  typedef logic [$clog2(`GAT_FEAT_DEPTH)-1:0] feat_addr_t;
  typedef logic [`GAT_FEAT_WIDTH-1:0] feat_val_t;
  typedef logic signed [`GAT_ACC_WIDTH-1:0] acc_t;

  // One Wh memory word, src_flag marks the first neighbor
  typedef struct packed {
    wh_val_t [`GAT_NUM_FEATURE_OUT-1:0] wh;
    node_cnt_t                          num_node;
    logic                               src_flag;
  } wh_entry_t;

  typedef struct packed {
    logic valid;
    logic first;
    logic last;
  } lane_ctrl_t;

  typedef struct packed {
    logic      valid;
    feat_val_t value;
  } lane_result_t;

  typedef enum logic {
    IDLE,
    RUN
  } fetch_state_t;

endpackage

// ==== src/alpha_fifo.sv ====
// Attention coefficient FIFO
`timescale 1ns/1ns
`include "gat_aggr_defines.svh"

module alpha_fifo (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  push,
  input  gat_aggr_pkg::alpha_t  push_data,
  input  logic                  pop,
  output gat_aggr_pkg::alpha_t  head,
  output logic                  empty,
  output logic                  full
);

  localparam int DEPTH = `GAT_ALPHA_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  gat_aggr_pkg::alpha_t mem [DEPTH];
  logic [PTR_W-1:0]     wr_ptr;
  logic [PTR_W-1:0]     rd_ptr;
  logic [PTR_W:0]       count;
  logic                 do_push;
  logic                 do_pop;

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign empty   = (count == '0);
  assign full    = (count == (PTR_W + 1)'(DEPTH));
  // Show-ahead head
  assign head    = mem[rd_ptr];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      count <= count + (PTR_W + 1)'(do_push) - (PTR_W + 1)'(do_pop);
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= push_data;
  end

  a_no_push_full : assert property (@(posedge clk) disable iff (!rst_n) push |-> !full);
  a_no_pop_empty : assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty);

endmodule

// ==== src/wh_store.sv ====
// Wh feature memory
`timescale 1ns/1ns
`include "gat_aggr_defines.svh"

module wh_store (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     wr_en,
  input  gat_aggr_pkg::wh_addr_t   wr_addr,
  input  gat_aggr_pkg::wh_entry_t  wr_data,
  input  gat_aggr_pkg::wh_addr_t   rd_addr,
  output gat_aggr_pkg::wh_entry_t  rd_data
);

  gat_aggr_pkg::wh_entry_t mem [`GAT_WH_DEPTH];

  // Port A, loader writes
  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_addr] <= wr_data;
  end

  // Port B, registered read
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_data <= '0;
    end else begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// ==== src/neighbor_fetch.sv ====
// Neighbor fetch stage
`timescale 1ns/1ns

module neighbor_fetch (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     fifo_empty,
  input  gat_aggr_pkg::alpha_t     fifo_head,
  output logic                     fifo_pop,
  input  logic                     stall,
  output gat_aggr_pkg::wh_addr_t   wh_rd_addr,
  input  gat_aggr_pkg::wh_entry_t  wh_rd_data,
  output gat_aggr_pkg::lane_ctrl_t lane_ctrl,
  output gat_aggr_pkg::alpha_t     lane_alpha,
  output gat_aggr_pkg::wh_entry_t  lane_wh
);

  gat_aggr_pkg::fetch_state_t state;
  gat_aggr_pkg::fetch_state_t state_next;
  gat_aggr_pkg::wh_addr_t     rd_addr;
  gat_aggr_pkg::alpha_t       alpha_q;
  gat_aggr_pkg::node_cnt_t    remain;
  gat_aggr_pkg::node_cnt_t    cnt_now;
  logic                       valid_q;
  logic                       is_last;

  // ====================================================================
  // Pop side
  // ====================================================================
  assign fifo_pop   = !fifo_empty && !stall;
  assign wh_rd_addr = rd_addr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_addr <= '0;
      valid_q <= 1'b0;
    end else begin
      if (fifo_pop) rd_addr <= rd_addr + 1'b1;
      valid_q <= fifo_pop;
    end
  end

  // Alpha lines up with the registered Wh read
  always_ff @(posedge clk) begin
    if (fifo_pop) alpha_q <= fifo_head;
  end

  // ====================================================================
  // Output stage
  // ====================================================================
  // Count still owed, including the current neighbor
  assign cnt_now = wh_rd_data.src_flag ? wh_rd_data.num_node : remain;
  assign is_last = (cnt_now == gat_aggr_pkg::node_cnt_t'(1));

  assign lane_ctrl.valid = valid_q;
  assign lane_ctrl.first = valid_q && wh_rd_data.src_flag;
  assign lane_ctrl.last  = valid_q && is_last;
  assign lane_alpha      = alpha_q;
  assign lane_wh         = wh_rd_data;

  always_comb begin
    state_next = state;
    case (state)
      gat_aggr_pkg::IDLE: if (valid_q && !is_last) state_next = gat_aggr_pkg::RUN;
      gat_aggr_pkg::RUN:  if (valid_q && is_last) state_next = gat_aggr_pkg::IDLE;
      default:            state_next = gat_aggr_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= gat_aggr_pkg::IDLE;
      remain <= '0;
    end else begin
      state <= state_next;
      if (valid_q) remain <= cnt_now - 1'b1;
    end
  end

  a_num_node_nonzero : assert property (@(posedge clk) disable iff (!rst_n)
    valid_q && wh_rd_data.src_flag |-> wh_rd_data.num_node != '0);

  // Subgraph boundaries in the Wh memory match the running count
  a_src_flag_boundary : assert property (@(posedge clk) disable iff (!rst_n)
    valid_q |-> wh_rd_data.src_flag == (state == gat_aggr_pkg::IDLE));

endmodule

// ==== src/feature_lane.sv ====
// Single feature multiply-accumulate lane
`timescale 1ns/1ns
`include "gat_aggr_defines.svh"

module feature_lane (
  input  logic                       clk,
  input  logic                       rst_n,
  input  gat_aggr_pkg::lane_ctrl_t   ctrl,
  input  gat_aggr_pkg::alpha_t       alpha,
  input  gat_aggr_pkg::wh_val_t      wh,
  output gat_aggr_pkg::lane_result_t result
);

  gat_aggr_pkg::lane_ctrl_t ctrl_q;
  gat_aggr_pkg::acc_t       prod_q;
  gat_aggr_pkg::acc_t       acc_q;
  gat_aggr_pkg::acc_t       acc_next;
  gat_aggr_pkg::feat_val_t  relu_val;
  gat_aggr_pkg::feat_val_t  res_value;
  logic                     res_valid;

  // Stage 2 sum, first neighbor restarts it
  assign acc_next = ctrl_q.first ? prod_q : acc_q + prod_q;
  assign relu_val = acc_next[`GAT_ACC_WIDTH-1] ? '0 : acc_next[`GAT_FEAT_WIDTH-1:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_q    <= '0;
      res_valid <= 1'b0;
    end else begin
      ctrl_q    <= ctrl;
      res_valid <= ctrl_q.valid && ctrl_q.last;
    end
  end

  always_ff @(posedge clk) begin
    // Stage 1, Wh integer times Q1.15 alpha
    prod_q <= gat_aggr_pkg::acc_t'(wh) * gat_aggr_pkg::acc_t'($signed({1'b0, alpha}));
    if (ctrl_q.valid) acc_q <= acc_next;
    if (ctrl_q.valid && ctrl_q.last) res_value <= relu_val;
  end

  assign result.valid = res_valid;
  assign result.value = res_value;

endmodule

// ==== src/feature_writer.sv ====
// Feature vector writer
`timescale 1ns/1ns
`include "gat_aggr_defines.svh"

module feature_writer (
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  logic                                             vec_valid,
  input  gat_aggr_pkg::feat_val_t [`GAT_NUM_FEATURE_OUT-1:0] vec_values,
  input  gat_aggr_pkg::feat_addr_t                         num_subgraphs,
  output logic                                             stall,
  output logic                                             feat_wr_en,
  output gat_aggr_pkg::feat_addr_t                         feat_wr_addr,
  output gat_aggr_pkg::feat_val_t                          feat_wr_data,
  output logic                                             aggr_done
);

  localparam int NF    = `GAT_NUM_FEATURE_OUT;
  localparam int IDX_W = $clog2(NF);
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NF - 1);

  gat_aggr_pkg::feat_val_t [NF-1:0] q_mem [2];
  gat_aggr_pkg::feat_val_t [NF-1:0] cur_vec;
  logic                             q_wr_ptr;
  logic                             q_rd_ptr;
  logic [1:0]                       q_cnt;
  logic                             busy;
  logic [IDX_W-1:0]                 word_idx;
  gat_aggr_pkg::feat_addr_t         addr_q;
  gat_aggr_pkg::feat_addr_t         sub_cnt;
  logic                             done_q;
  logic                             word_last;
  logic                             ser_free;
  logic                             q_pop;
  logic                             q_push;
  logic                             direct_load;

  // ====================================================================
  // Queue and serializer control
  // ====================================================================
  assign word_last   = busy && (word_idx == LAST_IDX);
  assign ser_free    = !busy || word_last;
  assign q_pop       = ser_free && (q_cnt != 2'd0);
  // Empty queue hands the vector straight to the serializer
  assign direct_load = ser_free && (q_cnt == 2'd0) && vec_valid;
  assign q_push      = vec_valid && !direct_load;

  // Arriving vector counts as held
  assign stall = vec_valid || busy || (q_cnt != 2'd0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      q_wr_ptr <= 1'b0;
      q_rd_ptr <= 1'b0;
      q_cnt    <= 2'd0;
      busy     <= 1'b0;
      word_idx <= '0;
      addr_q   <= '0;
      sub_cnt  <= '0;
      done_q   <= 1'b0;
    end else begin
      if (q_push) q_wr_ptr <= !q_wr_ptr;
      if (q_pop) q_rd_ptr <= !q_rd_ptr;
      q_cnt <= q_cnt + 2'(q_push) - 2'(q_pop);

      if (q_pop || direct_load) begin
        busy     <= 1'b1;
        word_idx <= '0;
      end else if (word_last) begin
        busy <= 1'b0;
      end else if (busy) begin
        word_idx <= word_idx + 1'b1;
      end

      if (busy) addr_q <= addr_q + 1'b1;
      if (word_last) begin
        sub_cnt <= sub_cnt + 1'b1;
        if (gat_aggr_pkg::feat_addr_t'(sub_cnt + 1'b1) == num_subgraphs) done_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (q_push) q_mem[q_wr_ptr] <= vec_values;
    if (q_pop) begin
      cur_vec <= q_mem[q_rd_ptr];
    end else if (direct_load) begin
      cur_vec <= vec_values;
    end
  end

  assign feat_wr_en   = busy;
  assign feat_wr_addr = addr_q;
  assign feat_wr_data = cur_vec[word_idx];
  assign aggr_done    = done_q;

  a_queue_no_overflow : assert property (@(posedge clk) disable iff (!rst_n)
    q_push |-> q_cnt < 2'd2);

endmodule

// ==== src/gat_aggregator.sv ====
// GAT attention aggregation top
`timescale 1ns/1ns
`include "gat_aggr_defines.svh"

module gat_aggregator (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     wh_wr_en,
  input  gat_aggr_pkg::wh_addr_t   wh_wr_addr,
  input  gat_aggr_pkg::wh_entry_t  wh_wr_data,
  input  logic                     alpha_push,
  input  gat_aggr_pkg::alpha_t     alpha_data,
  output logic                     alpha_full,
  input  gat_aggr_pkg::feat_addr_t num_subgraphs,
  output logic                     feat_wr_en,
  output gat_aggr_pkg::feat_addr_t feat_wr_addr,
  output gat_aggr_pkg::feat_val_t  feat_wr_data,
  output logic                     aggr_done
);

  gat_aggr_pkg::alpha_t                               fifo_head;
  logic                                               fifo_empty;
  logic                                               fifo_pop;
  logic                                               stall;
  gat_aggr_pkg::wh_addr_t                             wh_rd_addr;
  gat_aggr_pkg::wh_entry_t                            wh_rd_data;
  gat_aggr_pkg::lane_ctrl_t                           lane_ctrl;
  gat_aggr_pkg::alpha_t                               lane_alpha;
  gat_aggr_pkg::wh_entry_t                            lane_wh;
  gat_aggr_pkg::lane_result_t                         lane_result [`GAT_NUM_FEATURE_OUT];
  gat_aggr_pkg::feat_val_t [`GAT_NUM_FEATURE_OUT-1:0] lane_values;

  alpha_fifo alpha_fifo_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (alpha_push),
    .push_data (alpha_data),
    .pop       (fifo_pop),
    .head      (fifo_head),
    .empty     (fifo_empty),
    .full      (alpha_full)
  );

  wh_store wh_store_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_en   (wh_wr_en),
    .wr_addr (wh_wr_addr),
    .wr_data (wh_wr_data),
    .rd_addr (wh_rd_addr),
    .rd_data (wh_rd_data)
  );

  neighbor_fetch neighbor_fetch_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .fifo_empty (fifo_empty),
    .fifo_head  (fifo_head),
    .fifo_pop   (fifo_pop),
    .stall      (stall),
    .wh_rd_addr (wh_rd_addr),
    .wh_rd_data (wh_rd_data),
    .lane_ctrl  (lane_ctrl),
    .lane_alpha (lane_alpha),
    .lane_wh    (lane_wh)
  );

  // One lane per output feature
  for (genvar i = 0; i < `GAT_NUM_FEATURE_OUT; i++) begin : g_lane
    feature_lane feature_lane_i (
      .clk    (clk),
      .rst_n  (rst_n),
      .ctrl   (lane_ctrl),
      .alpha  (lane_alpha),
      .wh     (lane_wh.wh[i]),
      .result (lane_result[i])
    );
    assign lane_values[i] = lane_result[i].value;
  end

  feature_writer feature_writer_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .vec_valid     (lane_result[0].valid),
    .vec_values    (lane_values),
    .num_subgraphs (num_subgraphs),
    .stall         (stall),
    .feat_wr_en    (feat_wr_en),
    .feat_wr_addr  (feat_wr_addr),
    .feat_wr_data  (feat_wr_data),
    .aggr_done     (aggr_done)
  );

endmodule

// ==== tests/gat_aggr_checker.sv ====
// Feature write checker
`timescale 1ns/1ns
`include "gat_aggr_defines.svh"

module gat_aggr_checker (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     alpha_push,
  input  logic                     alpha_full,
  input  logic                     feat_wr_en,
  input  gat_aggr_pkg::feat_addr_t feat_wr_addr,
  input  gat_aggr_pkg::feat_val_t  feat_wr_data,
  input  logic                     aggr_done,
  output int                       error_count,
  output int                       write_count,
  output int                       pending_count
);

  // Expected writes in address order
  string                    exp_name [$];
  gat_aggr_pkg::feat_addr_t exp_addr [$];
  gat_aggr_pkg::feat_val_t  exp_data [$];
  string                    name;
  gat_aggr_pkg::feat_addr_t addr;
  gat_aggr_pkg::feat_val_t  data;
  logic                     done_prev;
  logic                     wr_prev;
  int                       push_total;

  initial begin
    error_count = 0;
    write_count = 0;
    done_prev   = 1'b0;
    wr_prev     = 1'b0;
    push_total  = 0;
  end

  task automatic add_expected(input string tname, input gat_aggr_pkg::feat_addr_t waddr,
                              input gat_aggr_pkg::feat_val_t wdata);
    exp_name.push_back(tname);
    exp_addr.push_back(waddr);
    exp_data.push_back(wdata);
    pending_count = exp_data.size();
  endtask

  always @(posedge clk) begin
    if (rst_n) begin
      // FIFO cannot fill before a full depth of coefficients has arrived
      if (alpha_full && push_total < `GAT_ALPHA_FIFO_DEPTH) begin
        $display("ERROR alpha_fifo_fill alpha_full expected 0 actual 1 after %0d pushes",
                 push_total);
        error_count++;
      end
      if (alpha_push) push_total++;

      if (feat_wr_en) begin
        write_count++;
        if (aggr_done) begin
          $display("Feature write to address %0d after aggr_done went high", feat_wr_addr);
          error_count++;
        end else if (exp_data.size() == 0) begin
          $display("Unexpected feature write to address %0d, none left to expect",
                   feat_wr_addr);
          error_count++;
        end else begin
          name = exp_name.pop_front();
          addr = exp_addr.pop_front();
          data = exp_data.pop_front();
          if (feat_wr_addr !== addr) begin
            $display("ERROR %s address expected %0d actual %0d", name, addr, feat_wr_addr);
            error_count++;
          end
          if (feat_wr_data !== data) begin
            $display("ERROR %s data expected %08h actual %08h", name, data, feat_wr_data);
            error_count++;
          end
        end
      end
      // Done must follow the very last write
      if (aggr_done && !done_prev) begin
        if (exp_data.size() != 0) begin
          $display("aggr_done rose with %0d feature writes outstanding", exp_data.size());
          error_count++;
        end else if (!wr_prev) begin
          $display("aggr_done did not rise the cycle after the last feature write");
          error_count++;
        end
      end
      done_prev     = aggr_done;
      wr_prev       = feat_wr_en;
      pending_count = exp_data.size();
    end
  end

endmodule

// ==== tests/gat_aggr_tb.sv ====
// GAT aggregator testbench
`timescale 1ns/1ns
`include "gat_aggr_defines.svh"

module gat_aggr_tb;

  localparam int NF           = `GAT_NUM_FEATURE_OUT;
  localparam int RESET_CYCLES = 10;

  logic                     clk;
  logic                     rst_n;
  logic                     wh_wr_en;
  gat_aggr_pkg::wh_addr_t   wh_wr_addr;
  gat_aggr_pkg::wh_entry_t  wh_wr_data;
  logic                     alpha_push;
  gat_aggr_pkg::alpha_t     alpha_data;
  logic                     alpha_full;
  gat_aggr_pkg::feat_addr_t num_subgraphs;
  logic                     feat_wr_en;
  gat_aggr_pkg::feat_addr_t feat_wr_addr;
  gat_aggr_pkg::feat_val_t  feat_wr_data;
  logic                     aggr_done;
  int                       error_count;
  int                       write_count;
  int                       pending_count;

  // Parsed stimulus, one slot per Wh entry
  gat_aggr_pkg::wh_entry_t  entries [`GAT_WH_DEPTH];
  gat_aggr_pkg::alpha_t     alphas [`GAT_WH_DEPTH];
  int                       n_entries;
  int                       n_sub;
  int                       setup_errors;
  int                       cycle_cnt;
  int                       cycle_limit;

  gat_aggregator dut_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .wh_wr_en      (wh_wr_en),
    .wh_wr_addr    (wh_wr_addr),
    .wh_wr_data    (wh_wr_data),
    .alpha_push    (alpha_push),
    .alpha_data    (alpha_data),
    .alpha_full    (alpha_full),
    .num_subgraphs (num_subgraphs),
    .feat_wr_en    (feat_wr_en),
    .feat_wr_addr  (feat_wr_addr),
    .feat_wr_data  (feat_wr_data),
    .aggr_done     (aggr_done)
  );

  gat_aggr_checker chk_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .alpha_push    (alpha_push),
    .alpha_full    (alpha_full),
    .feat_wr_en    (feat_wr_en),
    .feat_wr_addr  (feat_wr_addr),
    .feat_wr_data  (feat_wr_data),
    .aggr_done     (aggr_done),
    .error_count   (error_count),
    .write_count   (write_count),
    .pending_count (pending_count)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Watchdog on cycles since reset release
  always @(posedge clk) begin
    if (rst_n) begin
      cycle_cnt++;
      if (cycle_cnt > cycle_limit) begin
        $display("Timeout: aggr_done not seen within %0d cycles", cycle_limit);
        $display("test failed");
        $finish;
      end
    end
  end

  // ====================================================================
  // Case file parsing
  // ====================================================================
  task automatic read_cases();
    int              fd;
    int              first_idx;
    int              w [NF];
    logic [15:0]     al;
    logic [31:0]     e [NF];
    logic [8*24-1:0] name_bits;
    string           line;
    fd        = $fopen("tests/aggr_cases.txt", "r");
    first_idx = 0;
    if (fd == 0) begin
      $display("Cannot open the case file tests/aggr_cases.txt");
      setup_errors++;
      return;
    end
    while ($fgets(line, fd) > 0) begin
      if (line.len() > 1 && line[0] == "n") begin
        if ($sscanf(line, "n %d %d %d %d %h", w[0], w[1], w[2], w[3], al) != 5 ||
            n_entries >= `GAT_WH_DEPTH) begin
          $display("Bad neighbor line in case file: %s", line);
          setup_errors++;
        end else begin
          entries[n_entries] = '0;
          for (int k = 0; k < NF; k++) begin
            entries[n_entries].wh[k] = gat_aggr_pkg::wh_val_t'(w[k]);
          end
          alphas[n_entries] = al;
          n_entries++;
        end
      end else if (line.len() > 1 && line[0] == "e") begin
        if ($sscanf(line, "e %s %h %h %h %h", name_bits, e[0], e[1], e[2], e[3]) != 5 ||
            n_entries == first_idx || n_entries - first_idx > `GAT_MAX_NODES) begin
          $display("Bad expected line or neighbor count in case file: %s", line);
          setup_errors++;
        end else begin
          // First neighbor carries the count for the whole subgraph
          entries[first_idx].src_flag = 1'b1;
          entries[first_idx].num_node = gat_aggr_pkg::node_cnt_t'(n_entries - first_idx);
          for (int f = 0; f < NF; f++) begin
            chk_i.add_expected($sformatf("%0s f%0d", name_bits, f),
                               gat_aggr_pkg::feat_addr_t'(n_sub * NF + f), e[f]);
          end
          n_sub++;
        end
        first_idx = n_entries;
      end
    end
    $fclose(fd);
  endtask

  // ====================================================================
  // Main sequence
  // ====================================================================
  initial begin
    int i;
    int gap;
    rst_n         = 1'b0;
    wh_wr_en      = 1'b0;
    wh_wr_addr    = '0;
    wh_wr_data    = '0;
    alpha_push    = 1'b0;
    alpha_data    = '0;
    num_subgraphs = '0;
    n_entries     = 0;
    n_sub         = 0;
    setup_errors  = 0;
    cycle_cnt     = 0;
    void'($urandom(4968));
    read_cases();
    if (n_sub == 0) setup_errors++;
    num_subgraphs = gat_aggr_pkg::feat_addr_t'(n_sub);
    cycle_limit   = 20 * n_entries + 10 * NF * n_sub + 200;

    // Wh loading overlaps the reset window
    for (i = 0; i < RESET_CYCLES || i < n_entries; i++) begin
      @(posedge clk);
      wh_wr_en   <= (i < n_entries);
      wh_wr_addr <= gat_aggr_pkg::wh_addr_t'(i);
      wh_wr_data <= entries[i];
    end
    @(posedge clk);
    wh_wr_en <= 1'b0;
    rst_n    <= 1'b1;

    if (setup_errors == 0) begin
      i   = 0;
      gap = 0;
      while (i < n_entries) begin
        @(posedge clk);
        if (gap > 0 || alpha_full) begin
          alpha_push <= 1'b0;
          if (gap > 0) gap--;
        end else begin
          alpha_push <= 1'b1;
          alpha_data <= alphas[i];
          i++;
          // Idle gap after roughly one push in four
          gap = ($urandom % 4 == 0) ? int'($urandom % 3) + 1 : 0;
        end
      end
      @(posedge clk);
      alpha_push <= 1'b0;
      while (!aggr_done) @(posedge clk);
      // Extra cycles to catch stray writes
      repeat (8) @(posedge clk);
    end

    if (pending_count != 0) $display("Expected feature writes never seen: %0d", pending_count);
    $display("Writes checked %0d, errors %0d, missing %0d, setup errors %0d",
             write_count, error_count, pending_count, setup_errors);
    if (error_count == 0 && pending_count == 0 && setup_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== tests/aggr_cases.txt ====
# n wh0 wh1 wh2 wh3 alpha    one neighbor, Wh in signed decimal, alpha in hex (15 fraction bits)
# e name exp0 exp1 exp2 exp3 closes a subgraph, expected feature words in hex
n 10 -2 30 -5 4000
n 4 8 -12 100 2000
n -2 6 7 1 2000
e sum3_mixed 0002c000 00014000 0006e000 000b6000
n 2047 -2048 1 0 7fff
n -1000 1500 3 5 0003
e sum2_extremes 03ff6c49 00000000 00008008 0000000f
n -10 10 5 3 4000
n 4 -20 1 -1 4000
e relu_partial 00000000 00000000 00018000 00008000
n 100 -100 0 2047 8000
e single_unit 00320000 00000000 00000000 03ff8000
n -1 1 7 -7 0001
e single_tiny 00000000 00000001 00000007 00000000
n 12 34 56 78 ffff
e single_max_alpha 000bfff4 0021ffde 0037ffc8 004dffb2
n 0 0 0 1 1234
e single_one 00000000 00000000 00000000 00001234

// ==== compile.f ====
+incdir+src
src/gat_aggr_pkg.sv
src/alpha_fifo.sv
src/wh_store.sv
src/neighbor_fetch.sv
src/feature_lane.sv
src/feature_writer.sv
src/gat_aggregator.sv
tests/gat_aggr_checker.sv
tests/gat_aggr_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the GAT aggregator simulation with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module gat_aggr_tb -f compile.f \
  || { echo "Verilator build failed"; exit 1; }
sim_out="$(./obj_dir/Vgat_aggr_tb)"
echo "$sim_out"
echo "$sim_out" | grep -qx "test passed" && exit 0 || exit 1
